// ==== Bender.yml ====
package:
  name: gat_writeback

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/gat_pkg.sv
      - design/feat_fifo.sv
      - design/feature_controller.sv
      - design/feature_bram_apb.sv
      - design/gat_writeback_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - tests/gat_writeback_sva.sv
      - tests/gat_writeback_tb.sv

// ==== design/feat_fifo.sv ====
// ====================
// Synchronous FIFO of whole feature vectors.
// dout always shows the oldest entry, valid while empty is low.
// Push while full and pop while empty are ignored.
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "gat_params.svh"

module feat_fifo (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                push,
  input  wire gat_pkg::feat_vec_t din,
  input  wire                pop,
  output gat_pkg::feat_vec_t dout,
  output logic               empty,
  output logic               full
);

  gat_pkg::feat_vec_t         mem [`GAT_FIFO_DEPTH];
  logic [`GAT_FIFO_PTR_W-1:0] wr_ptr;
  logic [`GAT_FIFO_PTR_W-1:0] rd_ptr;
  logic [`GAT_FIFO_CNT_W-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == `GAT_FIFO_DEPTH);
  assign dout  = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // ====================
  // Pointers and occupancy
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == `GAT_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == `GAT_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/feature_bram_apb.sv ====
// ====================
// Feature memory with a controller write port and a read-only APB slave.
// Every access takes exactly one wait state.
// Words at byte address 4*k, status word at GAT_STATUS_ADDR.
// APB writes and unmapped reads end with pslverr and zero data.
// pwdata is not stored, the host cannot change memory contents.
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "gat_params.svh"

module feature_bram_apb (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      wr_en,
  input  wire gat_pkg::feat_addr_t wr_addr,
  input  wire gat_pkg::feat_word_t wr_data,
  input  wire                      layer_done,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire gat_pkg::apb_addr_t  paddr,
  input  wire gat_pkg::apb_data_t  pwdata,
  output gat_pkg::apb_data_t       prdata,
  output logic                     pready,
  output logic                     pslverr
);

  gat_pkg::feat_word_t        mem [`GAT_TOTAL_WORDS];
  logic [`GAT_STAT_CNT_W-1:0] wr_cnt_q;
  gat_pkg::apb_data_t         status_word;
  gat_pkg::feat_addr_t        rd_word;
  logic                       first_cyc;
  logic                       hit_mem;
  logic                       hit_status;
  logic                       bad;

  // ====================
  // Write port
  // ====================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Words stored so far, reported in the status word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt_q <= '0;
    end else if (wr_en) begin
      wr_cnt_q <= wr_cnt_q + 1'b1;
    end
  end

  always_comb begin
    status_word       = '0;
    status_word[0]    = layer_done;
    status_word[11:4] = wr_cnt_q;
  end

  // ====================
  // APB decode
  // ====================
  // First access cycle, pready still low
  assign first_cyc = psel && penable && !pready;

  assign hit_mem    = (paddr < 4 * `GAT_TOTAL_WORDS) && (paddr[1:0] == 2'b00);
  assign hit_status = (paddr == `GAT_STATUS_ADDR);
  assign bad        = pwrite || !(hit_mem || hit_status);
  assign rd_word    = paddr[`GAT_ADDR_W+1:2];

  // pready and pslverr only in the completing cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= first_cyc;
      pslverr <= first_cyc && bad;
    end
  end

  // Synchronous read, captured at the end of the first access cycle
  always_ff @(posedge clk) begin
    if (first_cyc) begin
      if (bad) begin
        prdata <= '0;
      end else if (hit_status) begin
        prdata <= status_word;
      end else begin
        prdata <= mem[rd_word];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/feature_controller.sv ====
// ====================
// Splits each popped vector into words, highest element first.
// First word goes out in the pop cycle, straight from the FIFO output.
// Four writes on four consecutive cycles per vector.
// layer_done is sticky until reset; later vectors are popped and dropped.
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "gat_params.svh"

module feature_controller (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire gat_pkg::feat_vec_t ff_dout,
  input  wire                 ff_empty,
  output logic                ff_pop,
  output logic                wr_en,
  output gat_pkg::feat_addr_t wr_addr,
  output gat_pkg::feat_word_t wr_data,
  output logic                layer_done
);

  gat_pkg::wb_state_t  state_q;
  gat_pkg::feat_vec_t  vec_q;
  gat_pkg::feat_vec_t  vec_src;
  gat_pkg::elem_idx_t  idx_q;
  gat_pkg::elem_idx_t  idx_cur;
  gat_pkg::feat_addr_t addr_q;
  logic                done_q;
  logic                start;

  // Take a vector whenever idle and one is waiting
  assign start  = (state_q == gat_pkg::WB_IDLE) && !ff_empty;
  assign ff_pop = start;

  assign wr_en = (start && !done_q) || (state_q == gat_pkg::WB_WRITE);

  // ====================
  // Word select
  // ====================
  always_comb begin
    if (state_q == gat_pkg::WB_IDLE) begin
      vec_src = ff_dout;
      idx_cur = gat_pkg::elem_idx_t'(`GAT_NUM_FEATURE_OUT - 1);
    end else begin
      vec_src = vec_q;
      idx_cur = idx_q;
    end
  end

  assign wr_data    = vec_src[idx_cur*`GAT_FEAT_WIDTH +: `GAT_FEAT_WIDTH];
  assign wr_addr    = addr_q;
  assign layer_done = done_q;

  // ====================
  // FSM, address and done flag
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= gat_pkg::WB_IDLE;
      idx_q   <= '0;
      addr_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        gat_pkg::WB_IDLE: begin
          if (start && !done_q) begin
            state_q <= gat_pkg::WB_WRITE;
            idx_q   <= gat_pkg::elem_idx_t'(`GAT_NUM_FEATURE_OUT - 2);
          end
        end
        gat_pkg::WB_WRITE: begin
          // Element 0 is the last word of the vector
          if (idx_q == '0) begin
            state_q <= gat_pkg::WB_IDLE;
          end
          idx_q <= idx_q - 1'b1;
        end
        default: begin
          state_q <= gat_pkg::WB_IDLE;
        end
      endcase

      if (wr_en) begin
        addr_q <= addr_q + 1'b1;
      end
      if (wr_en && (addr_q == gat_pkg::feat_addr_t'(`GAT_TOTAL_WORDS - 1))) begin
        done_q <= 1'b1;
      end
    end
  end

  // Vector held for the remaining three words
  always_ff @(posedge clk) begin
    if (start) begin
      vec_q <= ff_dout;
    end
  end

endmodule

`default_nettype wire

// ==== design/gat_params.svh ====
// ====================
// Fixed sizes of the write-back stage, sized small for simulation.
// GAT_FIFO_DEPTH must be a power of two for the pointer width to hold.
// GAT_TOTAL_WORDS must fit the memory address width.
// ====================
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// ====================
// Base sizes
// ====================
`define GAT_NUM_FEATURE_OUT 4
`define GAT_FEAT_WIDTH      32
`define GAT_NUM_SUBGRAPHS   8
`define GAT_FIFO_DEPTH      4

// ====================
// Derived sizes
// ====================
`define GAT_TOTAL_WORDS     (`GAT_NUM_SUBGRAPHS * `GAT_NUM_FEATURE_OUT)
`define GAT_ADDR_W          5
`define GAT_IDX_W           2
`define GAT_FIFO_PTR_W      2
`define GAT_FIFO_CNT_W      3

// APB map and status word layout
`define GAT_APB_ADDR_W      8
`define GAT_STATUS_ADDR     8'h80
`define GAT_STAT_CNT_W      8

`endif

// ==== design/gat_pkg.sv ====
// ====================
// Shared types of the write-back stage.
// Vector element 0 sits in the low bits of feat_vec_t.
// ====================
`default_nettype none

`include "gat_params.svh"

package gat_pkg;

  // One feature word and one whole vector
  typedef logic [`GAT_FEAT_WIDTH-1:0]                      feat_word_t;
  typedef logic [`GAT_NUM_FEATURE_OUT*`GAT_FEAT_WIDTH-1:0] feat_vec_t;

  // Memory word address and element index
  typedef logic [`GAT_ADDR_W-1:0]                          feat_addr_t;
  typedef logic [`GAT_IDX_W-1:0]                           elem_idx_t;

  // APB side
  typedef logic [`GAT_APB_ADDR_W-1:0]                      apb_addr_t;
  typedef logic [31:0]                                     apb_data_t;

  // Write-back controller FSM
  typedef enum logic {
    WB_IDLE,
    WB_WRITE
  } wb_state_t;

endpackage

`default_nettype wire

// ==== design/gat_writeback_top.sv ====
// ====================
// Write-back stage top: FIFO, controller, feature memory with APB.
// new_feat_rdy is combinational from the FIFO full flag.
// gat_ready stays high until reset.
// ====================
`default_nettype none
`timescale 1ns/1ns

module gat_writeback_top (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire gat_pkg::feat_vec_t  new_feat,
  input  wire                      new_feat_vld,
  output logic                     new_feat_rdy,
  output logic                     gat_ready,
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire gat_pkg::apb_addr_t  paddr,
  input  wire gat_pkg::apb_data_t  pwdata,
  output gat_pkg::apb_data_t       prdata,
  output logic                     pready,
  output logic                     pslverr
);

  gat_pkg::feat_vec_t  ff_dout;
  logic                ff_empty;
  logic                ff_full;
  logic                ff_pop;
  logic                ff_push;
  logic                wr_en;
  gat_pkg::feat_addr_t wr_addr;
  gat_pkg::feat_word_t wr_data;
  logic                layer_done;

  // Input handshake
  assign new_feat_rdy = !ff_full;
  assign ff_push      = new_feat_vld && new_feat_rdy;
  assign gat_ready    = layer_done;

  feat_fifo u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (ff_push),
    .din   (new_feat),
    .pop   (ff_pop),
    .dout  (ff_dout),
    .empty (ff_empty),
    .full  (ff_full)
  );

  feature_controller u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .ff_dout    (ff_dout),
    .ff_empty   (ff_empty),
    .ff_pop     (ff_pop),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .layer_done (layer_done)
  );

  feature_bram_apb u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .layer_done (layer_done),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/gat_pkg.sv
design/feat_fifo.sv
design/feature_controller.sv
design/feature_bram_apb.sv
design/gat_writeback_top.sv
tests/gat_writeback_sva.sv
tests/gat_writeback_tb.sv

// ==== tests/gat_writeback_sva.sv ====
// ====================
// Handshake and write sequence assertions, bound into the top level.
// All properties are disabled while reset is low.
// ====================
`default_nettype none
`timescale 1ns/1ns

module gat_writeback_sva (
  input wire                      clk,
  input wire                      rst_n,
  input wire                      wr_en,
  input wire gat_pkg::feat_addr_t wr_addr,
  input wire                      gat_ready,
  input wire                      psel,
  input wire                      penable,
  input wire                      pready,
  input wire gat_pkg::feat_vec_t  new_feat,
  input wire                      new_feat_vld,
  input wire                      new_feat_rdy
);

  // Words of one vector go out on consecutive cycles at rising addresses
  a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_en && (wr_addr[1:0] != 2'b11)) |=>
      (wr_en && (wr_addr == gat_pkg::feat_addr_t'($past(wr_addr) + 1'b1))))
    else $error("next word of a vector not written to the next address on the next cycle");

  a_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    gat_ready |=> gat_ready)
    else $error("gat_ready fell before reset");

  a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pready |-> (psel && penable))
    else $error("pready high outside an APB access phase");

  // Source holds its vector under back-pressure
  a_src_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (new_feat_vld && !new_feat_rdy) |=> (new_feat_vld && $stable(new_feat)))
    else $error("source changed its vector while new_feat_rdy was low");

endmodule

bind gat_writeback_top gat_writeback_sva u_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .wr_en        (wr_en),
  .wr_addr      (wr_addr),
  .gat_ready    (gat_ready),
  .psel         (psel),
  .penable      (penable),
  .pready       (pready),
  .new_feat     (new_feat),
  .new_feat_vld (new_feat_vld),
  .new_feat_rdy (new_feat_rdy)
);

`default_nettype wire

// ==== tests/gat_writeback_tb.sv ====
// ====================
// Testbench for the write-back stage top level.
// Inputs change and outputs are sampled on the falling clock edge.
// Phase one sends eight vectors back to back. Phase two follows a fresh reset
// and sends them with random gaps. Each phase reads back all 32 words over APB.
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "gat_params.svh"

module gat_writeback_tb;

  localparam int WAIT_LIMIT = 200;
  localparam int NW         = `GAT_NUM_FEATURE_OUT;
  localparam int FW         = `GAT_FEAT_WIDTH;

  logic                clk;
  logic                rst_n;
  gat_pkg::feat_vec_t  new_feat;
  logic                new_feat_vld;
  logic                new_feat_rdy;
  logic                gat_ready;
  logic                psel;
  logic                penable;
  logic                pwrite;
  gat_pkg::apb_addr_t  paddr;
  gat_pkg::apb_data_t  pwdata;
  gat_pkg::apb_data_t  prdata;
  logic                pready;
  logic                pslverr;

  gat_pkg::feat_vec_t  sent_q [$];
  int                  seed;
  int                  fail_count;
  int                  timeout_count;
  logic                rdy_low_seen;
  logic                ready_seen;

  gat_writeback_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .new_feat     (new_feat),
    .new_feat_vld (new_feat_vld),
    .new_feat_rdy (new_feat_rdy),
    .gat_ready    (gat_ready),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

  always #10 clk = ~clk;

  // ====================
  // Reference model and checks
  // ====================
  // Word k holds element 3 - (k mod 4) of vector k div 4
  function automatic gat_pkg::feat_word_t ref_word(input int k);
    gat_pkg::feat_vec_t vec;
    int                 elem;
    vec = '0;
    if (k / NW < sent_q.size()) begin
      vec = sent_q[k / NW];
    end
    elem = NW - 1 - (k % NW);
    return vec[elem*FW +: FW];
  endfunction

  function automatic gat_pkg::feat_vec_t random_vector();
    gat_pkg::feat_vec_t vec;
    for (int i = 0; i < NW; i++) begin
      vec[i*FW +: FW] = $random(seed);
    end
    return vec;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // Once high, gat_ready must stay high until the next reset
  always @(negedge clk) begin
    if (!rst_n) begin
      ready_seen = 1'b0;
    end else begin
      if (ready_seen) begin
        check_value("gat_ready", gat_ready, 1'b1);
      end
      ready_seen = gat_ready;
    end
  end

  // ====================
  // Drivers
  // ====================
  task automatic do_reset();
    @(negedge clk);
    rst_n = 1'b0;
    sent_q.delete();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Holds the vector until accepted, then idles for gap cycles
  task automatic send_vector(input gat_pkg::feat_vec_t vec, input int gap);
    int waited;
    waited       = 0;
    new_feat     = vec;
    new_feat_vld = 1'b1;
    while (!new_feat_rdy && waited < WAIT_LIMIT) begin
      rdy_low_seen = 1'b1;
      @(negedge clk);
      waited++;
    end
    if (!new_feat_rdy) begin
      timeout_count++;
      $display("Error: timed out waiting for new_feat_rdy at %0t ns", $time);
    end else begin
      @(negedge clk);
      sent_q.push_back(vec);
    end
    if (gap > 0) begin
      new_feat_vld = 1'b0;
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic apb_access(input logic write, input gat_pkg::apb_addr_t addr,
                            input gat_pkg::apb_data_t wdata,
                            output gat_pkg::apb_data_t rdata, output logic err);
    int waited;
    waited  = 0;
    rdata   = '0;
    err     = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // One wait state, pready still low in the first access cycle
    check_value("pready", pready, 1'b0);
    do begin
      @(negedge clk);
      waited++;
    end while (!pready && waited < WAIT_LIMIT);
    if (!pready) begin
      timeout_count++;
      $display("Error: APB access to 0x%02h got no pready at %0t ns", addr, $time);
    end else begin
      check_value("wait states", waited, 1);
      rdata = prdata;
      err   = pslverr;
    end
    // Transfer completes on the next rising edge
    @(negedge clk);
    check_value("pready", pready, 1'b0);
    check_value("pslverr", pslverr, 1'b0);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic wait_layer_done();
    int waited;
    waited = 0;
    while (!gat_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!gat_ready) begin
      timeout_count++;
      $display("Error: timed out waiting for gat_ready at %0t ns", $time);
    end
  endtask

  task automatic readback_all();
    gat_pkg::apb_data_t rdata;
    logic               err;
    for (int k = 0; k < `GAT_TOTAL_WORDS; k++) begin
      apb_access(1'b0, gat_pkg::apb_addr_t'(4 * k), '0, rdata, err);
      check_value($sformatf("prdata[word %0d]", k), rdata, ref_word(k));
      check_value("pslverr", err, 1'b0);
    end
    apb_access(1'b0, `GAT_STATUS_ADDR, '0, rdata, err);
    check_value("status", rdata, 32'h0000_0201);
    check_value("pslverr", err, 1'b0);
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    gat_pkg::apb_data_t rdata;
    logic               err;
    clk           = 1'b0;
    rst_n         = 1'b0;
    new_feat      = '0;
    new_feat_vld  = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    seed          = 25503;
    fail_count    = 0;
    timeout_count = 0;
    rdy_low_seen  = 1'b0;
    ready_seen    = 1'b0;

    do_reset();
    check_value("gat_ready", gat_ready, 1'b0);
    check_value("new_feat_rdy", new_feat_rdy, 1'b1);
    apb_access(1'b0, `GAT_STATUS_ADDR, '0, rdata, err);
    check_value("status", rdata, 32'h0);
    check_value("pslverr", err, 1'b0);

    // Back-to-back vectors fill the FIFO and cause back-pressure
    for (int i = 0; i < `GAT_NUM_SUBGRAPHS; i++) begin
      send_vector(random_vector(), 0);
    end
    new_feat_vld = 1'b0;
    if (!rdy_low_seen) begin
      fail_count++;
      $display("Error: new_feat_rdy never dropped while the FIFO was full");
    end
    wait_layer_done();
    readback_all();

    // Host writes and unmapped reads are refused
    apb_access(1'b1, 8'h14, 32'hdead_beef, rdata, err);
    check_value("pslverr", err, 1'b1);
    check_value("prdata", rdata, 32'h0);
    apb_access(1'b1, `GAT_STATUS_ADDR, 32'hffff_ffff, rdata, err);
    check_value("pslverr", err, 1'b1);
    check_value("prdata", rdata, 32'h0);
    apb_access(1'b0, 8'h84, '0, rdata, err);
    check_value("pslverr", err, 1'b1);
    check_value("prdata", rdata, 32'h0);
    apb_access(1'b0, 8'h14, '0, rdata, err);
    check_value("prdata[word 5]", rdata, ref_word(5));
    check_value("pslverr", err, 1'b0);
    check_value("gat_ready", gat_ready, 1'b1);

    // Second layer pass with random gaps between vectors
    do_reset();
    check_value("gat_ready", gat_ready, 1'b0);
    check_value("new_feat_rdy", new_feat_rdy, 1'b1);
    for (int i = 0; i < `GAT_NUM_SUBGRAPHS; i++) begin
      check_value("gat_ready", gat_ready, 1'b0);
      send_vector(random_vector(), {$random(seed)} % 6);
    end
    new_feat_vld = 1'b0;
    wait_layer_done();
    readback_all();

    $display("Check failures: %0d, timeouts: %0d", fail_count, timeout_count);
    if (fail_count == 0 && timeout_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
